//--- src/cheat_pkg.sv
// Cheat program store package with widths, word types, descramble key and packer states
package cheat_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    localparam int ADDR_W          = 10;                        // Program RAM address width
    localparam int WORD_W          = 18;                        // Coprocessor instruction width
    localparam int BYTE_W          = 8;                         // Download bus width
    localparam int BYTES_PER_GROUP = 9;                         // Nine bytes carry four words
    localparam int CNT_W           = $clog2(BYTES_PER_GROUP);   // Byte position counter width
    localparam int BUF_W           = 2 * BYTE_W;                // Leftover bit buffer width

    // ----------------------------------------
    // Descramble key
    // ----------------------------------------
    // The low byte is mixed with the download address to build the swap mask.
    // The high byte is folded into the data between the two swap stages.
    localparam logic [2*BYTE_W-1:0] SCRAMBLE_KEY = 16'hA55A;

    // ----------------------------------------
    // Types
    // ----------------------------------------
    typedef logic [BYTE_W-1:0] prog_byte_t;   // One download byte or its address
    typedef logic [WORD_W-1:0] instr_t;       // One instruction word
    typedef logic [ADDR_W-1:0] iaddr_t;       // One program RAM address

    // Packer control states
    typedef enum logic {
        PACK_IDLE,   // Waiting for prog_en to rise
        PACK_LOAD    // Accepting download bytes
    } pack_state_t;

endpackage

//--- src/cheat_descramble.sv
// Byte descrambler that undoes the keyed swap and XOR applied to the cheat program download
`timescale 1ns/100ps

module cheat_descramble (
    input  logic                 descramble_en,   // High applies the key and low passes data
    input  cheat_pkg::prog_byte_t byte_addr,      // Download address of this byte
    input  cheat_pkg::prog_byte_t byte_in,        // Raw byte from the download stream
    output cheat_pkg::prog_byte_t byte_out        // Byte ready for packing
);

    import cheat_pkg::*;

    prog_byte_t mask;     // Per-byte swap selection
    prog_byte_t stage1;   // After the first swap stage
    prog_byte_t stage2;   // After the key XOR

    // Swaps the two bits of each pair whose select bit is set
    function automatic prog_byte_t swap_pairs(prog_byte_t data, logic [3:0] sel);
        prog_byte_t res;
        res = data;
        for (int i = 0; i < 4; i++) begin
            if (sel[i]) begin
                res[2*i +: 2] = {data[2*i], data[2*i+1]};   // Exchange bit 2i and bit 2i+1
            end
        end
        return res;
    endfunction

    // ----------------------------------------
    // Swap, XOR, swap
    // ----------------------------------------
    assign mask   = byte_addr ^ SCRAMBLE_KEY[BYTE_W-1:0];        // Address dependent mask
    assign stage1 = swap_pairs(byte_in, mask[3:0]);              // Low mask nibble picks pairs
    assign stage2 = stage1 ^ SCRAMBLE_KEY[2*BYTE_W-1:BYTE_W];    // High key byte flips bits

    // High mask nibble runs the second swap over the same pairs
    assign byte_out = descramble_en ? swap_pairs(stage2, mask[7:4]) : byte_in;

endmodule

//--- src/cheat_word_packer.sv
// Download packer that turns groups of nine bytes into four 18-bit program RAM writes
`timescale 1ns/100ps

module cheat_word_packer (
    input  logic                  clk_rom,         // Download clock
    input  logic                  rst_n,           // Asynchronous reset, active low
    input  logic                  prog_en,         // High for the whole download
    input  logic                  prog_wr,         // One strobe per byte
    input  logic                  descramble_en,   // Static level during a download
    input  cheat_pkg::prog_byte_t prog_addr,       // Byte address, valid with prog_wr
    input  cheat_pkg::prog_byte_t prog_data,       // Byte data, valid with prog_wr
    output cheat_pkg::instr_t     wr_data,         // Assembled instruction word
    output cheat_pkg::iaddr_t     wr_addr,         // Next RAM address and word count
    output logic                  wr_en            // One cycle write strobe
);

    import cheat_pkg::*;

    pack_state_t      state;       // Packer FSM state
    logic             prog_en_q;   // Registered prog_en for edge detection
    logic [CNT_W-1:0] byte_cnt;    // Position of the next byte inside its group
    logic [BUF_W-1:0] shift_buf;   // Last two bytes, newest in the upper half
    prog_byte_t       byte_dsc;    // Descrambled incoming byte
    logic             start;       // Rising edge of prog_en
    logic             byte_take;   // A byte is accepted this cycle
    logic             word_done;   // This byte completes a word
    logic             last_byte;   // This byte closes the group

    cheat_descramble cheat_descramble_inst (
        .descramble_en (descramble_en),
        .byte_addr     (prog_addr),
        .byte_in       (prog_data),
        .byte_out      (byte_dsc)
    );

    // ----------------------------------------
    // Byte qualification
    // ----------------------------------------
    assign start     = prog_en && !prog_en_q;                            // Restart the download
    assign byte_take = (state == PACK_LOAD) && prog_en && prog_wr && !start;
    assign word_done = (byte_cnt != '0) && !byte_cnt[0];                 // Positions 2, 4, 6, 8
    assign last_byte = (byte_cnt == CNT_W'(BYTES_PER_GROUP - 1));        // Position 8

    // ----------------------------------------
    // Control path
    // ----------------------------------------
    always_ff @(posedge clk_rom or negedge rst_n) begin
        if (!rst_n) begin
            prog_en_q <= 1'b0;
            state     <= PACK_IDLE;
            byte_cnt  <= '0;
            wr_en     <= 1'b0;
            wr_addr   <= '0;
        end else begin
            prog_en_q <= prog_en;
            wr_en     <= 1'b0;                          // Strobe lasts one cycle by default
            if (start) begin
                state    <= PACK_LOAD;                  // A strobe in this cycle is dropped
                byte_cnt <= '0;
                wr_addr  <= '0;
            end else begin
                if (wr_en) begin
                    wr_addr <= wr_addr + 1'b1;          // Step after the RAM took the word
                end
                if (state == PACK_LOAD && !prog_en) begin
                    state <= PACK_IDLE;                 // Download finished
                end
                if (byte_take) begin
                    byte_cnt <= last_byte ? '0 : byte_cnt + 1'b1;
                    wr_en    <= word_done;
                end
            end
        end
    end

    // ----------------------------------------
    // Data path
    // ----------------------------------------
    // Each word takes the buffered leftover bits as its low part and the
    // bottom of the new byte as its top part
    always_ff @(posedge clk_rom) begin
        if (byte_take) begin
            shift_buf <= {byte_dsc, shift_buf[BUF_W-1:BYTE_W]};   // Keep the last two bytes
            case (byte_cnt)
                CNT_W'(2): wr_data <= {byte_dsc[1:0], shift_buf};          // Bits 0 to 17
                CNT_W'(4): wr_data <= {byte_dsc[3:0], shift_buf[15:2]};    // Bits 18 to 35
                CNT_W'(6): wr_data <= {byte_dsc[5:0], shift_buf[15:4]};    // Bits 36 to 53
                CNT_W'(8): wr_data <= {byte_dsc, shift_buf[15:6]};         // Bits 54 to 71
                default: ;
            endcase
        end
    end

endmodule

//--- src/cheat_dual_ram.sv
// Dual-clock program RAM with a download write port and a registered fetch read port
`timescale 1ns/100ps

module cheat_dual_ram (
    input  logic              clk_rom,    // Write side clock
    input  logic              clk_pico,   // Read side clock
    input  logic              wr_en,      // Write strobe
    input  cheat_pkg::iaddr_t wr_addr,    // Write address
    input  cheat_pkg::iaddr_t rd_addr,    // Read address
    input  cheat_pkg::instr_t wr_data,    // Word to store
    output cheat_pkg::instr_t rd_data     // Word read one clk_pico edge after rd_addr
);

    import cheat_pkg::*;

    localparam int DEPTH = 2 ** ADDR_W;   // One entry per program address

    instr_t mem [DEPTH];                  // Program storage

    // ----------------------------------------
    // Write port
    // ----------------------------------------
    always_ff @(posedge clk_rom) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;      // Takes effect at this clk_rom edge
        end
    end

    // ----------------------------------------
    // Read port
    // ----------------------------------------
    // A read of an address being written in the other domain returns an
    // undefined word
    always_ff @(posedge clk_pico) begin
        rd_data <= mem[rd_addr];          // One cycle read latency
    end

endmodule

//--- src/cheat_fetch.sv
// Instruction fetch unit that steps a program counter through the program RAM
`timescale 1ns/100ps

module cheat_fetch (
    input  logic              clk_pico,      // Coprocessor clock
    input  logic              rst_n,         // Asynchronous reset, active low
    input  logic              run,           // High lets the counter advance
    input  logic              jump,          // One cycle load request
    input  cheat_pkg::iaddr_t jump_addr,     // Target address, valid with jump
    input  cheat_pkg::instr_t rd_data,       // Word returned by the RAM
    output cheat_pkg::iaddr_t rd_addr,       // Address sent to the RAM
    output cheat_pkg::iaddr_t pc,            // Program counter
    output cheat_pkg::instr_t instr,         // Current instruction
    output logic              instr_valid    // instr holds a requested word
);

    // ----------------------------------------
    // Program counter
    // ----------------------------------------
    always_ff @(posedge clk_pico or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (jump) begin
            pc <= jump_addr;                 // Jump wins over run
        end else if (run) begin
            pc <= pc + 1'b1;                 // One instruction per cycle
        end
    end

    // ----------------------------------------
    // Valid tracking
    // ----------------------------------------
    // The RAM samples rd_addr at every edge. A word counts as requested
    // only when that edge also moved the counter forward, so the read of
    // the old address after a jump is discarded
    always_ff @(posedge clk_pico or negedge rst_n) begin
        if (!rst_n) begin
            instr_valid <= 1'b0;
        end else begin
            instr_valid <= run && !jump;     // Falls as soon as run drops
        end
    end

    assign rd_addr = pc;                     // Next read always follows the counter
    assign instr   = rd_data;                // The RAM register holds the word

endmodule

//--- src/cheat_rom_top.sv
// Cheat program store top joining the download packer, program RAM and fetch unit
`timescale 1ns/100ps

module cheat_rom_top (
    input  logic                  clk_rom,         // Download clock
    input  logic                  clk_pico,        // Coprocessor clock
    input  logic                  rst_n,           // Shared asynchronous reset, active low
    // Download side on clk_rom
    input  logic                  prog_en,         // High for the whole download
    input  logic                  prog_wr,         // One strobe per byte
    input  cheat_pkg::prog_byte_t prog_addr,       // Byte address
    input  cheat_pkg::prog_byte_t prog_data,       // Byte data
    input  logic                  descramble_en,   // Key enable for this download
    output cheat_pkg::iaddr_t     word_count,      // Words written since download start
    // Coprocessor side on clk_pico
    input  logic                  run,             // Fetch enable level
    input  logic                  jump,            // Counter load pulse
    input  cheat_pkg::iaddr_t     jump_addr,       // Counter load value
    output cheat_pkg::iaddr_t     pc,              // Program counter
    output cheat_pkg::instr_t     instr,           // Fetched instruction
    output logic                  instr_valid      // Fetched instruction is valid
);

    import cheat_pkg::*;

    instr_t wr_data;   // Packed word to the RAM
    logic   wr_en;     // RAM write strobe
    iaddr_t rd_addr;   // Fetch address to the RAM
    instr_t rd_data;   // RAM read data to the fetch unit

    // The packer write address doubles as the word count
    cheat_word_packer cheat_word_packer_inst (
        .clk_rom       (clk_rom),
        .rst_n         (rst_n),
        .prog_en       (prog_en),
        .prog_wr       (prog_wr),
        .descramble_en (descramble_en),
        .prog_addr     (prog_addr),
        .prog_data     (prog_data),
        .wr_data       (wr_data),
        .wr_addr       (word_count),
        .wr_en         (wr_en)
    );

    cheat_dual_ram cheat_dual_ram_inst (
        .clk_rom  (clk_rom),
        .clk_pico (clk_pico),
        .wr_en    (wr_en),
        .wr_addr  (word_count),
        .rd_addr  (rd_addr),
        .wr_data  (wr_data),
        .rd_data  (rd_data)
    );

    cheat_fetch cheat_fetch_inst (
        .clk_pico    (clk_pico),
        .rst_n       (rst_n),
        .run         (run),
        .jump        (jump),
        .jump_addr   (jump_addr),
        .rd_data     (rd_data),
        .rd_addr     (rd_addr),
        .pc          (pc),
        .instr       (instr),
        .instr_valid (instr_valid)
    );

endmodule

//--- verif/cheat_rom_tb.sv
// Directed testbench for the cheat program store covering download, descramble and fetch
`timescale 1ns/100ps

module cheat_rom_tb;

    import cheat_pkg::*;

    logic       clk_rom;          // Download clock, 4 ns
    logic       clk_pico;         // Coprocessor clock, 6 ns
    logic       rst_n;            // Shared reset, active low
    logic       prog_en;
    logic       prog_wr;
    prog_byte_t prog_addr;
    prog_byte_t prog_data;
    logic       descramble_en;
    iaddr_t     word_count;
    logic       run;
    logic       jump;
    iaddr_t     jump_addr;
    iaddr_t     pc;
    instr_t     instr;
    logic       instr_valid;

    integer     seed;             // Random stream state
    int         error_count;      // Failed checks over the whole run
    int         test_count;       // Finished tests
    int         failed_tests;     // Tests with at least one failed check
    prog_byte_t dl_bytes [64];    // Bytes of the current download
    instr_t     exp_mem [2**ADDR_W];   // Expected RAM contents

    cheat_rom_top cheat_rom_top_inst (.*);

    initial begin
        clk_rom = 1'b0;
        forever #2 clk_rom = ~clk_rom;
    end

    initial begin
        clk_pico = 1'b0;
        forever #3 clk_pico = ~clk_pico;
    end

    // Bytes plus fetch cycles, at the slower period, with a wide margin
    initial begin
        int limit_ns;
        limit_ns = (49 + 25) * 6 * 10;
        #(limit_ns);
        $display("Watchdog expired after %0d ns before the tests finished", limit_ns);
        $display("SOME TESTS FAILED");
        $finish;
    end

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic prog_byte_t swap_bit_pair(prog_byte_t data, int pair);
        prog_byte_t res;
        res             = data;
        res[2*pair]     = data[2*pair+1];
        res[2*pair+1]   = data[2*pair];
        return res;
    endfunction

    function automatic prog_byte_t model_descramble(prog_byte_t addr, prog_byte_t data);
        prog_byte_t mask;
        prog_byte_t val;
        mask = addr ^ 8'h5A;                       // Low byte of key A55A
        val  = data;
        for (int i = 0; i < 4; i++) begin
            if (mask[i]) val = swap_bit_pair(val, i);
        end
        val = val ^ 8'hA5;                         // High byte of key A55A
        for (int i = 0; i < 4; i++) begin
            if (mask[4+i]) val = swap_bit_pair(val, i);
        end
        return val;
    endfunction

    // Every complete 18-bit slice of the byte stream becomes one word
    task automatic build_model(int n_bytes, logic descr);
        logic [8*64-1:0] bits;
        prog_byte_t      b;
        bits = '0;
        for (int k = 0; k < n_bytes; k++) begin
            b = dl_bytes[k];
            if (descr) b = model_descramble(prog_byte_t'(k), b);
            bits[8*k +: 8] = b;                    // Little-endian bit string
        end
        for (int j = 0; j < (8 * n_bytes) / 18; j++) begin
            exp_mem[j] = bits[18*j +: 18];
        end
    endtask

    // ----------------------------------------
    // Drivers and checkers
    // ----------------------------------------
    task automatic compare_value(string name, logic [31:0] got, logic [31:0] expected);
        if (got !== expected) begin
            $display("ERROR t=%0t %s: got 0x%0h expected 0x%0h", $time, name, got, expected);
            error_count++;
        end
    endtask

    // A low cycle on prog_en makes every call a fresh download
    task automatic download_bytes(int n_bytes, logic descr);
        @(negedge clk_rom);
        prog_en = 1'b0;
        @(negedge clk_rom);
        descramble_en = descr;
        prog_en       = 1'b1;
        @(negedge clk_rom);                        // Edge between restarts the packer
        for (int i = 0; i < n_bytes; i++) begin
            prog_wr   = 1'b1;
            prog_addr = prog_byte_t'(i);
            prog_data = dl_bytes[i];
            @(negedge clk_rom);
        end
        prog_wr = 1'b0;
    endtask

    task automatic wait_word_count(int expected);
        int cycles;
        cycles = 0;
        while (word_count !== iaddr_t'(expected) && cycles < 10) begin
            @(negedge clk_rom);
            cycles++;
        end
        if (word_count !== iaddr_t'(expected)) begin
            $display("word_count did not reach %0d within 10 clk_rom cycles", expected);
            error_count++;
        end
        repeat (3) @(negedge clk_rom);             // A stray write would show here
        compare_value("word_count", 32'(word_count), expected);
    endtask

    // Jump to start, run for n_words edges, then drop run
    task automatic fetch_words(int start, int n_words);
        @(negedge clk_pico);
        jump      = 1'b1;
        jump_addr = iaddr_t'(start);
        run       = 1'b0;
        @(negedge clk_pico);
        compare_value("pc", 32'(pc), start);
        jump = 1'b0;
        run  = 1'b1;
        for (int i = 0; i < n_words; i++) begin
            @(negedge clk_pico);
            compare_value("instr_valid", 32'(instr_valid), 1);
            compare_value("instr", 32'(instr), 32'(exp_mem[start+i]));
            compare_value("pc", 32'(pc), start + i + 1);
        end
        run = 1'b0;
        repeat (2) begin
            @(negedge clk_pico);
            compare_value("instr_valid", 32'(instr_valid), 0);
            compare_value("pc", 32'(pc), start + n_words);   // Counter holds
        end
    endtask

    task automatic report_test(string name, int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("%s: passed", name);
        end else begin
            failed_tests++;
            $display("%s: failed with %0d errors", name, error_count - errors_before);
        end
    endtask

    // ----------------------------------------
    // Tests
    // ----------------------------------------
    task automatic check_reset_state();
        int errs;
        errs = error_count;
        @(negedge clk_pico);
        compare_value("word_count", 32'(word_count), 0);
        compare_value("instr_valid", 32'(instr_valid), 0);
        compare_value("pc", 32'(pc), 0);
        report_test("reset state", errs);
    endtask

    task automatic run_plain_download();
        prog_byte_t known [9] = '{8'h3C, 8'hA1, 8'h5F, 8'h07, 8'hE2, 8'h94, 8'h6B, 8'hD8, 8'h1E};
        int         errs;
        errs = error_count;
        for (int i = 0; i < 9; i++) dl_bytes[i] = known[i];
        build_model(9, 1'b0);
        download_bytes(9, 1'b0);
        wait_word_count(4);
        fetch_words(0, 4);
        report_test("plain download", errs);
    endtask

    // 27 bytes fill three groups and the last 4 complete only one more word
    task automatic run_scrambled_download();
        int errs;
        errs = error_count;
        for (int i = 0; i < 31; i++) dl_bytes[i] = prog_byte_t'($random(seed));
        build_model(31, 1'b1);
        download_bytes(31, 1'b1);
        wait_word_count(13);
        fetch_words(0, 13);
        report_test("scrambled download", errs);
    endtask

    // Words 4 and up keep the previous download
    task automatic restart_download();
        int errs;
        errs = error_count;
        for (int i = 0; i < 9; i++) dl_bytes[i] = prog_byte_t'($random(seed));
        build_model(9, 1'b1);
        download_bytes(9, 1'b1);
        wait_word_count(4);
        fetch_words(0, 5);
        report_test("restarted download", errs);
    endtask

    task automatic jump_and_stop();
        int errs;
        errs = error_count;
        fetch_words(7, 3);                         // Ends with pc at 10
        report_test("jump and stop", errs);
    endtask

    initial begin
        seed          = 32'hb70b;
        error_count   = 0;
        test_count    = 0;
        failed_tests  = 0;
        rst_n         = 1'b0;
        prog_en       = 1'b0;
        prog_wr       = 1'b0;
        prog_addr     = '0;
        prog_data     = '0;
        descramble_en = 1'b0;
        run           = 1'b0;
        jump          = 1'b0;
        jump_addr     = '0;
        repeat (4) @(negedge clk_rom);
        rst_n = 1'b1;
        check_reset_state();
        run_plain_download();
        run_scrambled_download();
        restart_download();
        jump_and_stop();
        $display("Tests run %0d, tests failed %0d, failed checks %0d",
                 test_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- flist.f
src/cheat_pkg.sv
src/cheat_descramble.sv
src/cheat_word_packer.sv
src/cheat_dual_ram.sv
src/cheat_fetch.sv
src/cheat_rom_top.sv
verif/cheat_rom_tb.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing -Wno-fatal
TOP      := cheat_rom_tb
FLIST    := flist.f
BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, fail unless the log shows a pass"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD) -o V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
